//--- alu/aluCore.sv
`timescale 1ns/1ps
`include "datapath_params.svh"

module aluCore (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`DATA_WIDTH-1:0] busValue,
    input  aluPkg::aluOpT          aluOp,
    input  logic                   yLoad,
    input  logic                   zLoad,
    cpuBusIf.source                bus
);

    localparam int ResultWidth = 2 * `DATA_WIDTH;

    logic [`DATA_WIDTH-1:0] yReg;        // Held operand A
    logic [ResultWidth-1:0] zReg;        // Split result register
    logic [ResultWidth-1:0] aluResult;
    logic [4:0]             shiftAmount;
    logic [`DATA_WIDTH-1:0] lowResult;

    assign shiftAmount = busValue[4:0];

    // 32-bit operations, upper half of Z gets zero
    always_comb begin
        case (aluOp)
            aluPkg::opAdd:  lowResult = yReg + busValue;
            aluPkg::opSub:  lowResult = yReg - busValue;
            aluPkg::opAnd:  lowResult = yReg & busValue;
            aluPkg::opOr:   lowResult = yReg | busValue;
            aluPkg::opShl:  lowResult = yReg << shiftAmount;
            aluPkg::opShr:  lowResult = yReg >> shiftAmount;   // Logical shift
            aluPkg::opPass: lowResult = busValue;
            default:        lowResult = '0;
        endcase
    end

    // Multiply is the only op that fills both halves
    always_comb begin
        if (aluOp == aluPkg::opMul) begin
            aluResult = ResultWidth'(yReg) * ResultWidth'(busValue);
        end else begin
            aluResult = {{`DATA_WIDTH{1'b0}}, lowResult};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            yReg <= '0;
            zReg <= '0;
        end else begin
            if (yLoad) yReg <= busValue;
            if (zLoad) zReg <= aluResult;
        end
    end

    assign bus.zHighValue = zReg[ResultWidth-1:`DATA_WIDTH];
    assign bus.zLowValue  = zReg[`DATA_WIDTH-1:0];

endmodule

//--- common/aluPkg.sv
package aluPkg;

    // ALU operation codes, multiply keeps code 5
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opOr   = 4'd3,
        opShl  = 4'd6,
        opShr  = 4'd7,
        opMul  = 4'd5,
        opPass = 4'd8
    } aluOpT;

endpackage

//--- common/busPkg.sv
package busPkg;

    // Bus driver select
    // Low codes pick the register file, the rest follow the legacy select map
    typedef enum logic [4:0] {
        srcGp    = 5'd0,   // Register file at gpAddr
        srcHi    = 5'd16,
        srcLo    = 5'd17,
        srcZHigh = 5'd18,
        srcZLow  = 5'd19,
        srcPc    = 5'd20,
        srcMdr   = 5'd21,
        srcIr    = 5'd22,
        srcNone  = 5'd31   // Bus reads zero
    } busSrcT;

endpackage

//--- common/cpuBusIf.sv
`timescale 1ns/1ps
`include "datapath_params.svh"

interface cpuBusIf;

    logic [`DATA_WIDTH-1:0] busValue;    // Shared bus
    logic [`DATA_WIDTH-1:0] gpValue;     // Addressed general-purpose register
    logic [`DATA_WIDTH-1:0] pcValue;
    logic [`DATA_WIDTH-1:0] irValue;
    logic [`DATA_WIDTH-1:0] mdrValue;
    logic [`DATA_WIDTH-1:0] hiValue;
    logic [`DATA_WIDTH-1:0] loValue;
    logic [`DATA_WIDTH-1:0] zHighValue;
    logic [`DATA_WIDTH-1:0] zLowValue;

    // Register blocks present their contents here
    modport source (
        output gpValue, pcValue, irValue, mdrValue, hiValue, loValue, zHighValue, zLowValue
    );

    modport mux (
        input  gpValue, pcValue, irValue, mdrValue, hiValue, loValue, zHighValue, zLowValue,
        output busValue
    );

    modport sink (
        input busValue
    );

endinterface

//--- common/datapath_params.svh
`ifndef DATAPATH_PARAMS_SVH
`define DATAPATH_PARAMS_SVH

// Word width of the bus and of every register
`define DATA_WIDTH 32

// General-purpose register file size
`define REG_COUNT 16
`define REG_ADDR_WIDTH 4

`endif

//--- design/busDatapath.sv
`timescale 1ns/1ps
`include "datapath_params.svh"

module busDatapath (
    input  logic                       clock,
    input  logic                       reset,
    input  busPkg::busSrcT             busSrc,
    input  logic [`REG_ADDR_WIDTH-1:0] gpAddr,
    input  logic                       gpLoad,
    input  logic                       pcLoad,
    input  logic                       incPc,
    input  logic                       irLoad,
    input  logic                       marLoad,
    input  logic                       mdrLoad,
    input  logic                       mdrRead,
    input  logic                       yLoad,
    input  logic                       zLoad,
    input  logic                       hiLoad,
    input  logic                       loLoad,
    input  aluPkg::aluOpT              aluOp,
    input  logic [`DATA_WIDTH-1:0]     memData,
    output logic [`DATA_WIDTH-1:0]     busOut,
    output logic [`DATA_WIDTH-1:0]     marValue,
    output logic [`DATA_WIDTH-1:0]     hiOut,
    output logic [`DATA_WIDTH-1:0]     loOut
);

    cpuBusIf cpuBus ();

    registerFile gpRegs (
        .clock    (clock),
        .reset    (reset),
        .gpAddr   (gpAddr),
        .gpLoad   (gpLoad),
        .busValue (cpuBus.busValue),
        .bus      (cpuBus.source)
    );

    specialRegisters specRegs (
        .clock    (clock),
        .reset    (reset),
        .busValue (cpuBus.busValue),
        .memData  (memData),
        .pcLoad   (pcLoad),
        .incPc    (incPc),
        .irLoad   (irLoad),
        .marLoad  (marLoad),
        .mdrLoad  (mdrLoad),
        .mdrRead  (mdrRead),
        .hiLoad   (hiLoad),
        .loLoad   (loLoad),
        .marValue (marValue),   // Memory address leaves directly
        .bus      (cpuBus.source)
    );

    aluCore alu (
        .clock    (clock),
        .reset    (reset),
        .busValue (cpuBus.busValue),
        .aluOp    (aluOp),
        .yLoad    (yLoad),
        .zLoad    (zLoad),
        .bus      (cpuBus.source)
    );

    busMux mux (
        .busSrc (busSrc),
        .bus    (cpuBus.mux)
    );

    assign busOut = cpuBus.busValue;
    assign hiOut  = cpuBus.hiValue;   // Multiply result halves
    assign loOut  = cpuBus.loValue;

endmodule

//--- design/busMux.sv
`timescale 1ns/1ps

module busMux (
    input  busPkg::busSrcT busSrc,
    cpuBusIf.mux           bus
);

    // Single driver for the shared bus
    always_comb begin
        case (busSrc)
            busPkg::srcGp:    bus.busValue = bus.gpValue;
            busPkg::srcHi:    bus.busValue = bus.hiValue;
            busPkg::srcLo:    bus.busValue = bus.loValue;
            busPkg::srcZHigh: bus.busValue = bus.zHighValue;
            busPkg::srcZLow:  bus.busValue = bus.zLowValue;
            busPkg::srcPc:    bus.busValue = bus.pcValue;
            busPkg::srcMdr:   bus.busValue = bus.mdrValue;
            busPkg::srcIr:    bus.busValue = bus.irValue;
            default:          bus.busValue = '0;   // srcNone and unused codes
        endcase
    end

endmodule

//--- list.f
+incdir+common
common/aluPkg.sv
common/busPkg.sv
common/cpuBusIf.sv
registers/registerFile.sv
registers/specialRegisters.sv
alu/aluCore.sv
design/busMux.sv
design/busDatapath.sv
sim/datapath_properties.sv
sim/datapathTb.sv

//--- registers/registerFile.sv
`timescale 1ns/1ps
`include "datapath_params.svh"

module registerFile (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [`REG_ADDR_WIDTH-1:0] gpAddr,
    input  logic                       gpLoad,
    input  logic [`DATA_WIDTH-1:0]     busValue,
    cpuBusIf.source                    bus
);

    logic [`DATA_WIDTH-1:0] gpRegs [`REG_COUNT];

    // One write port, addressed register captures the bus
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                gpRegs[i] <= '0;
            end
        end else if (gpLoad) begin
            gpRegs[gpAddr] <= busValue;
        end
    end

    // Same address reads back combinationally
    assign bus.gpValue = gpRegs[gpAddr];

endmodule

//--- registers/specialRegisters.sv
`timescale 1ns/1ps
`include "datapath_params.svh"

module specialRegisters (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`DATA_WIDTH-1:0] busValue,
    input  logic [`DATA_WIDTH-1:0] memData,
    input  logic                   pcLoad,
    input  logic                   incPc,
    input  logic                   irLoad,
    input  logic                   marLoad,
    input  logic                   mdrLoad,
    input  logic                   mdrRead,
    input  logic                   hiLoad,
    input  logic                   loLoad,
    output logic [`DATA_WIDTH-1:0] marValue,
    cpuBusIf.source                bus
);

    logic [`DATA_WIDTH-1:0] pcReg;
    logic [`DATA_WIDTH-1:0] irReg;
    logic [`DATA_WIDTH-1:0] marReg;
    logic [`DATA_WIDTH-1:0] mdrReg;
    logic [`DATA_WIDTH-1:0] hiReg;
    logic [`DATA_WIDTH-1:0] loReg;
    logic [`DATA_WIDTH-1:0] mdrNext;

    // Memory read takes priority over the bus
    assign mdrNext = mdrRead ? memData : busValue;

    always_ff @(posedge clock) begin
        if (reset) begin
            pcReg  <= '0;
            irReg  <= '0;
            marReg <= '0;
            mdrReg <= '0;
            hiReg  <= '0;
            loReg  <= '0;
        end else begin
            if (pcLoad) begin
                pcReg <= busValue;   // Jump beats increment
            end else if (incPc) begin
                pcReg <= pcReg + `DATA_WIDTH'(1);
            end
            if (irLoad)  irReg  <= busValue;
            if (marLoad) marReg <= busValue;
            if (mdrLoad) mdrReg <= mdrNext;
            if (hiLoad)  hiReg  <= busValue;
            if (loLoad)  loReg  <= busValue;
        end
    end

    assign marValue     = marReg;
    assign bus.pcValue  = pcReg;
    assign bus.irValue  = irReg;
    assign bus.mdrValue = mdrReg;
    assign bus.hiValue  = hiReg;
    assign bus.loValue  = loReg;

endmodule

//--- sim/datapathTb.sv
`timescale 1ns/1ps
`include "datapath_params.svh"

module datapathTb;

    // Cycle budget per test, used for the watchdog
    localparam int ResetCycles  = 2;
    localparam int IdleCycles   = 10;
    localparam int MdrCycles    = 25;
    localparam int MulCycles    = 46;
    localparam int AluCycles    = 55;
    localparam int PcCycles     = 13;
    localparam int MarCycles    = 17;
    localparam int CycleLimit   = ResetCycles + IdleCycles + MdrCycles + MulCycles
                                  + AluCycles + PcCycles + MarCycles + 40;

    logic                       clock;
    logic                       reset;
    busPkg::busSrcT             busSrc;
    logic [`REG_ADDR_WIDTH-1:0] gpAddr;
    logic                       gpLoad, pcLoad, incPc, irLoad, marLoad, mdrLoad, mdrRead;
    logic                       yLoad, zLoad, hiLoad, loLoad;
    aluPkg::aluOpT              aluOp;
    logic [`DATA_WIDTH-1:0]     memData;
    logic [`DATA_WIDTH-1:0]     busOut, marValue, hiOut, loOut;
    int                         passCount = 0;
    int                         failCount = 0;
    int                         cycleCount = 0;
    int                         errorsAtStart;

    busDatapath DUT (.*);

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", CycleLimit);
            $display("test failed");
            $finish;
        end
    end

    task automatic clearControls();
        busSrc  = busPkg::srcNone;
        {gpLoad, pcLoad, incPc, irLoad, marLoad, mdrLoad, mdrRead} = '0;
        {yLoad, zLoad, hiLoad, loLoad} = '0;
        aluOp   = aluPkg::opPass;
        gpAddr  = '0;
        memData = '0;
    endtask

    // Apply the control word at the next edge
    task automatic advance();
        @(posedge clock);
        #1;
        clearControls();
    endtask

    task automatic loadGp(input logic [`REG_ADDR_WIDTH-1:0] addr,
                          input logic [`DATA_WIDTH-1:0] value);
        memData = value;
        mdrRead = 1'b1;
        mdrLoad = 1'b1;
        advance();
        busSrc = busPkg::srcMdr;   // MDR to register file
        gpAddr = addr;
        gpLoad = 1'b1;
        advance();
    endtask

    task automatic reportTest(input string name);
        advance();   // Last loads reach the outputs
        if (DUT.props.errorCount == errorsAtStart) begin
            passCount++;
            $display("PASS %s", name);
        end else begin
            failCount++;
            $display("FAIL %s (%0d assertion errors)", name, DUT.props.errorCount - errorsAtStart);
        end
    endtask

    task automatic runAluOp(input aluPkg::aluOpT op, input logic [`DATA_WIDTH-1:0] a,
                            input logic [`DATA_WIDTH-1:0] b);
        loadGp(1, a);
        loadGp(2, b);
        busSrc = busPkg::srcGp;
        gpAddr = 1;
        yLoad  = 1'b1;
        advance();
        busSrc = busPkg::srcGp;
        gpAddr = 2;
        aluOp  = op;
        zLoad  = 1'b1;
        advance();
        busSrc = busPkg::srcZLow;
        loLoad = 1'b1;
        advance();
        busSrc = busPkg::srcZHigh;
        hiLoad = 1'b1;
        advance();
        advance();
    endtask

    task automatic checkResetOutputs();
        busPkg::busSrcT sources [9] = '{busPkg::srcGp, busPkg::srcHi, busPkg::srcLo,
            busPkg::srcZHigh, busPkg::srcZLow, busPkg::srcPc, busPkg::srcMdr,
            busPkg::srcIr, busPkg::srcNone};
        errorsAtStart = DUT.props.errorCount;
        foreach (sources[i]) begin
            busSrc = sources[i];
            gpAddr = i;
            advance();
        end
        reportTest("resetOutputs");
    endtask

    task automatic checkMdrToGp();
        logic [`REG_ADDR_WIDTH-1:0] addr;
        errorsAtStart = DUT.props.errorCount;
        repeat (8) begin
            addr = $urandom_range(`REG_COUNT - 1);
            loadGp(addr, $urandom);
            busSrc = busPkg::srcGp;
            gpAddr = addr;
            advance();
        end
        reportTest("mdrToGp");
    endtask

    task automatic checkMultiply();
        errorsAtStart = DUT.props.errorCount;
        runAluOp(aluPkg::opMul, 6, 4);
        repeat (4) runAluOp(aluPkg::opMul, $urandom, $urandom);
        reportTest("multiply");
    endtask

    task automatic checkAluOps();
        aluPkg::aluOpT ops [6] = '{aluPkg::opAdd, aluPkg::opSub, aluPkg::opAnd,
            aluPkg::opOr, aluPkg::opShl, aluPkg::opShr};
        errorsAtStart = DUT.props.errorCount;
        foreach (ops[i]) runAluOp(ops[i], $urandom, $urandom);
        reportTest("aluOps");
    endtask

    task automatic checkPc();
        errorsAtStart = DUT.props.errorCount;
        repeat (8) begin
            busSrc = busPkg::srcPc;
            incPc  = 1'b1;
            advance();
        end
        loadGp(3, $urandom);
        busSrc = busPkg::srcGp;   // Load and increment together
        gpAddr = 3;
        pcLoad = 1'b1;
        incPc  = 1'b1;
        advance();
        busSrc = busPkg::srcPc;
        advance();
        reportTest("programCounter");
    endtask

    task automatic checkMar();
        errorsAtStart = DUT.props.errorCount;
        repeat (4) begin
            loadGp(4, $urandom);
            busSrc  = busPkg::srcGp;
            gpAddr  = 4;
            marLoad = 1'b1;
            advance();
            advance();   // MAR holds without marLoad
        end
        reportTest("memoryAddress");
    endtask

    initial begin
        void'($urandom(32'h840d));
        clock = 1'b0;
        reset = 1'b1;
        clearControls();
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        checkResetOutputs();
        checkMdrToGp();
        checkMultiply();
        checkAluOps();
        checkPc();
        checkMar();
        $display("Tests finished: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- sim/datapath_properties.sv
`timescale 1ns/1ps
`include "datapath_params.svh"

module datapathProperties (
    input logic                       clock,
    input logic                       reset,
    input busPkg::busSrcT             busSrc,
    input logic [`REG_ADDR_WIDTH-1:0] gpAddr,
    input logic                       gpLoad,
    input logic                       pcLoad,
    input logic                       incPc,
    input logic                       irLoad,
    input logic                       marLoad,
    input logic                       mdrLoad,
    input logic                       mdrRead,
    input logic                       yLoad,
    input logic                       zLoad,
    input logic                       hiLoad,
    input logic                       loLoad,
    input aluPkg::aluOpT              aluOp,
    input logic [`DATA_WIDTH-1:0]     memData,
    input logic [`DATA_WIDTH-1:0]     busOut,
    input logic [`DATA_WIDTH-1:0]     marValue,
    input logic [`DATA_WIDTH-1:0]     hiOut,
    input logic [`DATA_WIDTH-1:0]     loOut
);

    logic [`DATA_WIDTH-1:0]   gpShadow [`REG_COUNT];
    logic [`DATA_WIDTH-1:0]   pcShadow;
    logic [`DATA_WIDTH-1:0]   irShadow;
    logic [`DATA_WIDTH-1:0]   marShadow;
    logic [`DATA_WIDTH-1:0]   mdrShadow;
    logic [`DATA_WIDTH-1:0]   hiShadow;
    logic [`DATA_WIDTH-1:0]   loShadow;
    logic [`DATA_WIDTH-1:0]   yShadow;
    logic [2*`DATA_WIDTH-1:0] zShadow;
    logic [`DATA_WIDTH-1:0]   expBus;    // Bus value the select should produce
    int                       errorCount = 0;

    // Reference result of one ALU operation on Y and the bus
    function automatic logic [2*`DATA_WIDTH-1:0] expectedResult(
        input aluPkg::aluOpT op,
        input logic [`DATA_WIDTH-1:0] a,
        input logic [`DATA_WIDTH-1:0] b
    );
        logic [4:0] amount;
        amount = b[4:0];
        if (op == aluPkg::opMul) return {{`DATA_WIDTH{1'b0}}, a} * {{`DATA_WIDTH{1'b0}}, b};
        if (op == aluPkg::opAdd) return {{`DATA_WIDTH{1'b0}}, a + b};
        if (op == aluPkg::opSub) return {{`DATA_WIDTH{1'b0}}, a - b};
        if (op == aluPkg::opAnd) return {{`DATA_WIDTH{1'b0}}, a & b};
        if (op == aluPkg::opOr) return {{`DATA_WIDTH{1'b0}}, a | b};
        if (op == aluPkg::opShl) return {{`DATA_WIDTH{1'b0}}, a << amount};
        if (op == aluPkg::opShr) return {{`DATA_WIDTH{1'b0}}, a >> amount};
        if (op == aluPkg::opPass) return {{`DATA_WIDTH{1'b0}}, b};
        return '0;
    endfunction

    always_comb begin
        case (busSrc)
            busPkg::srcGp:    expBus = gpShadow[gpAddr];
            busPkg::srcHi:    expBus = hiShadow;
            busPkg::srcLo:    expBus = loShadow;
            busPkg::srcZHigh: expBus = zShadow[2*`DATA_WIDTH-1:`DATA_WIDTH];
            busPkg::srcZLow:  expBus = zShadow[`DATA_WIDTH-1:0];
            busPkg::srcPc:    expBus = pcShadow;
            busPkg::srcMdr:   expBus = mdrShadow;
            busPkg::srcIr:    expBus = irShadow;
            default:          expBus = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) gpShadow[i] <= '0;
            pcShadow  <= '0;
            irShadow  <= '0;
            marShadow <= '0;
            mdrShadow <= '0;
            hiShadow  <= '0;
            loShadow  <= '0;
            yShadow   <= '0;
            zShadow   <= '0;
        end else begin
            if (gpLoad) gpShadow[gpAddr] <= expBus;
            if (pcLoad) pcShadow <= expBus;   // Load wins over increment
            else if (incPc) pcShadow <= pcShadow + 1;
            if (irLoad) irShadow <= expBus;
            if (marLoad) marShadow <= expBus;
            if (mdrLoad) mdrShadow <= mdrRead ? memData : expBus;
            if (hiLoad) hiShadow <= expBus;
            if (loLoad) loShadow <= expBus;
            if (yLoad) yShadow <= expBus;
            if (zLoad) zShadow <= expectedResult(aluOp, yShadow, expBus);
        end
    end

    busMatches: assert property (@(posedge clock) disable iff (reset) busOut == expBus)
        else begin
            errorCount++;
            $error("ERROR %0t: busOut %h, expected %h", $time, $sampled(busOut),
                $sampled(expBus));
        end

    marMatches: assert property (@(posedge clock) disable iff (reset) marValue == marShadow)
        else begin
            errorCount++;
            $error("ERROR %0t: marValue %h, expected %h", $time, $sampled(marValue),
                $sampled(marShadow));
        end

    resultMatches: assert property (@(posedge clock) disable iff (reset)
        hiOut == hiShadow && loOut == loShadow)
        else begin
            errorCount++;
            $error("ERROR %0t: hi/lo %h/%h, expected %h/%h", $time, $sampled(hiOut),
                $sampled(loOut), $sampled(hiShadow), $sampled(loShadow));
        end

endmodule

bind busDatapath datapathProperties props (.*);
